//--- verilog/plane_ray_cfg.svh
`ifndef PLANE_RAY_CFG_SVH
`define PLANE_RAY_CFG_SVH

// Datapath widths
`define COORD_W         16
`define DATA_W          64      // Holds the 54-bit worst case of a dot product

`define NUM_LANES       6
`define NUM_COORDS      15
`define MAC_LATENCY     2       // Issue to result, in cycles

// AXI4-Lite bus
`define AXI_ADDR_W      8
`define AXI_DATA_W      32

// Register map
`define REG_CTRL        8'h00   // Bit 0 starts the engine
`define REG_STATUS      8'h04   // Bit 0 busy, bit 1 done
`define REG_NUM_LO      8'h08
`define REG_NUM_HI      8'h0C
`define REG_DEN_LO      8'h10
`define REG_DEN_HI      8'h14
`define REG_COORD_BASE  8'h40   // Coordinate i at base + 4*i, order p0 p1 p2 r0 rd

`endif

//--- verilog/plane_ray_pkg.sv
`default_nettype none
`include "plane_ray_cfg.svh"

package plane_ray_pkg;

    typedef logic signed [`COORD_W-1:0] coord_t;   // One input coordinate
    typedef logic signed [`DATA_W-1:0]  data_t;    // Lane operand or result

    typedef struct packed {
        data_t x;
        data_t y;
        data_t z;
    } vec3_t;

    // Lane opcodes
    typedef enum logic [1:0] {
        OP_SUB,     // a - c
        OP_MUL,     // a * b
        OP_MAC,     // a * b + c
        OP_NMAC     // c - a * b
    } mac_op_t;

    typedef enum logic [3:0] {
        IDLE,
        VDIFF,      // AB and AC
        VDIFF_PR,   // PR, overlaps the VDIFF results
        NORM_MUL,   // Positive cross terms
        NORM_SUB,   // Minus the negative cross terms
        DOT_X,
        DOT_Y,
        DOT_Z,
        FINISH
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/plane_ray_if.sv
`default_nettype none
`include "plane_ray_cfg.svh"

interface plane_ray_if;

    plane_ray_pkg::coord_t coords [`NUM_COORDS];   // p0 p1 p2 r0 rd, xyz each
    logic                  start;                  // One-cycle pulse
    logic                  busy;
    logic                  done;                   // One-cycle pulse
    plane_ray_pkg::data_t  num;                    // PR . n
    plane_ray_pkg::data_t  den;                    // rd . n

    modport regs (
        output coords,
        output start,
        input  busy,
        input  done,
        input  num,
        input  den
    );

    modport core (
        input  coords,
        input  start,
        output busy,
        output done,
        output num,
        output den
    );

endinterface

`default_nettype wire

//--- verilog/mac_lane.sv
`default_nettype none
`include "plane_ray_cfg.svh"

module mac_lane (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           valid_i,
    input  wire plane_ray_pkg::mac_op_t   op_i,
    input  wire plane_ray_pkg::data_t     a_i,
    input  wire plane_ray_pkg::data_t     b_i,
    input  wire plane_ray_pkg::data_t     c_i,
    output logic                          valid_o,
    output plane_ray_pkg::data_t          result_o
);

    plane_ray_pkg::data_t    prod_q;
    plane_ray_pkg::data_t    addend_q;
    plane_ray_pkg::mac_op_t  op_q;
    logic [`MAC_LATENCY-1:0] vld_q;     // Valid travels beside the payload

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[`MAC_LATENCY-2:0], valid_i};
        end
    end

    assign valid_o = vld_q[`MAC_LATENCY-1];

    // Stage 1, product and addend
    always_ff @(posedge clk) begin
        if (valid_i) begin
            prod_q   <= (op_i == plane_ray_pkg::OP_SUB) ? a_i : a_i * b_i;   // SUB passes a
            addend_q <= c_i;
            op_q     <= op_i;
        end
    end

    // Stage 2, apply the opcode
    always_ff @(posedge clk) begin
        if (vld_q[0]) begin
            case (op_q)
                plane_ray_pkg::OP_SUB: result_o <= prod_q - addend_q;
                plane_ray_pkg::OP_MUL: result_o <= prod_q;
                plane_ray_pkg::OP_MAC: result_o <= prod_q + addend_q;
                default:               result_o <= addend_q - prod_q;   // NMAC
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/plane_ray_regs.sv
`default_nettype none
`include "plane_ray_cfg.svh"

module plane_ray_regs (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [`AXI_ADDR_W-1:0]    s_axi_awaddr_i,
    input  wire                      s_axi_awvalid_i,
    output logic                     s_axi_awready_o,
    input  wire [`AXI_DATA_W-1:0]    s_axi_wdata_i,
    input  wire [`AXI_DATA_W/8-1:0]  s_axi_wstrb_i,
    input  wire                      s_axi_wvalid_i,
    output logic                     s_axi_wready_o,
    output logic [1:0]               s_axi_bresp_o,
    output logic                     s_axi_bvalid_o,
    input  wire                      s_axi_bready_i,
    input  wire [`AXI_ADDR_W-1:0]    s_axi_araddr_i,
    input  wire                      s_axi_arvalid_i,
    output logic                     s_axi_arready_o,
    output logic [`AXI_DATA_W-1:0]   s_axi_rdata_o,
    output logic [1:0]               s_axi_rresp_o,
    output logic                     s_axi_rvalid_o,
    input  wire                      s_axi_rready_i,
    plane_ray_if.regs                bus
);

    localparam int IDX_W = $clog2(`NUM_COORDS);

    logic                   wr_accept;
    logic                   rd_accept;
    logic                   done_flag;     // STATUS bit 1
    logic [`AXI_DATA_W-1:0] rd_data;
    plane_ray_pkg::coord_t  rd_coord;

    // Word-aligned address inside the coordinate window
    function automatic logic coord_hit(logic [`AXI_ADDR_W-1:0] addr);
        logic [`AXI_ADDR_W-1:0] offs;
        offs = addr - `REG_COORD_BASE;
        return (addr >= `REG_COORD_BASE) && (offs[1:0] == 2'b00)
            && (offs[`AXI_ADDR_W-1:2] < `NUM_COORDS);
    endfunction

    function automatic logic [IDX_W-1:0] coord_idx(logic [`AXI_ADDR_W-1:0] addr);
        logic [`AXI_ADDR_W-1:0] offs;
        offs = addr - `REG_COORD_BASE;
        return offs[IDX_W+1:2];
    endfunction

    // ----------------------------------------------------------
    // Write channel
    // ----------------------------------------------------------
    assign wr_accept       = s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_bvalid_o;
    assign s_axi_awready_o = wr_accept;
    assign s_axi_wready_o  = wr_accept;
    assign s_axi_bresp_o   = 2'b00;   // OKAY

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_axi_bvalid_o <= 1'b0;
            bus.start      <= 1'b0;
            done_flag      <= 1'b0;
            for (int i = 0; i < `NUM_COORDS; i++) begin
                bus.coords[i] <= '0;
            end
        end else begin
            bus.start <= 1'b0;
            if (wr_accept) begin
                s_axi_bvalid_o <= 1'b1;
            end else if (s_axi_bready_i) begin
                s_axi_bvalid_o <= 1'b0;
            end

            // No new start while a run is underway
            if (wr_accept && s_axi_awaddr_i == `REG_CTRL) begin
                bus.start <= s_axi_wstrb_i[0] && s_axi_wdata_i[0] && !bus.busy;
            end

            if (wr_accept && coord_hit(s_axi_awaddr_i)) begin
                for (int b = 0; b < `COORD_W / 8; b++) begin
                    if (s_axi_wstrb_i[b]) begin
                        bus.coords[coord_idx(s_axi_awaddr_i)][8*b +: 8] <= s_axi_wdata_i[8*b +: 8];
                    end
                end
            end

            if (bus.start) begin
                done_flag <= 1'b0;
            end else if (bus.done) begin
                done_flag <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Read channel
    // ----------------------------------------------------------
    assign rd_accept       = s_axi_arvalid_i && !s_axi_rvalid_o;
    assign s_axi_arready_o = rd_accept;
    assign s_axi_rresp_o   = 2'b00;

    always_comb begin
        rd_coord = bus.coords[coord_idx(s_axi_araddr_i)];
        rd_data  = '0;                     // CTRL and holes read as zero
        case (s_axi_araddr_i)
            `REG_STATUS: rd_data = {{(`AXI_DATA_W-2){1'b0}}, done_flag, bus.busy};
            `REG_NUM_LO: rd_data = bus.num[31:0];
            `REG_NUM_HI: rd_data = bus.num[63:32];
            `REG_DEN_LO: rd_data = bus.den[31:0];
            `REG_DEN_HI: rd_data = bus.den[63:32];
            default: begin
                if (coord_hit(s_axi_araddr_i)) begin
                    // Sign-extended to the bus width
                    rd_data = {{(`AXI_DATA_W-`COORD_W){rd_coord[`COORD_W-1]}}, rd_coord};
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_axi_rvalid_o <= 1'b0;
        end else if (rd_accept) begin
            s_axi_rvalid_o <= 1'b1;
        end else if (s_axi_rready_i) begin
            s_axi_rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            s_axi_rdata_o <= rd_data;   // Held while rvalid waits
        end
    end

endmodule

`default_nettype wire

//--- verilog/plane_ray_ctrl.sv
`default_nettype none
`include "plane_ray_cfg.svh"

module plane_ray_ctrl (
    input  wire        clk,
    input  wire        rst_n,
    plane_ray_if.core  bus
);

    plane_ray_pkg::ctrl_state_t state;
    logic                       issued;     // Stage has sent its operations
    int unsigned                dot_idx;    // Component of the current DOT stage

    // Latched inputs
    plane_ray_pkg::vec3_t p0;
    plane_ray_pkg::vec3_t p1;
    plane_ray_pkg::vec3_t p2;
    plane_ray_pkg::vec3_t r0;
    plane_ray_pkg::vec3_t rd;

    // Intermediate results
    plane_ray_pkg::vec3_t ab;
    plane_ray_pkg::vec3_t ac;
    plane_ray_pkg::vec3_t pr;
    plane_ray_pkg::vec3_t cross_pos;
    plane_ray_pkg::vec3_t nrm;
    plane_ray_pkg::data_t num_acc;
    plane_ray_pkg::data_t den_acc;

    logic [`NUM_LANES-1:0]  lane_en;
    logic [`NUM_LANES-1:0]  lane_vi;
    logic [`NUM_LANES-1:0]  lane_vo;
    plane_ray_pkg::mac_op_t lane_op  [`NUM_LANES];
    plane_ray_pkg::data_t   lane_a   [`NUM_LANES];
    plane_ray_pkg::data_t   lane_b   [`NUM_LANES];
    plane_ray_pkg::data_t   lane_c   [`NUM_LANES];
    plane_ray_pkg::data_t   lane_res [`NUM_LANES];

    function automatic plane_ray_pkg::vec3_t to_vec(plane_ray_pkg::coord_t x,
                                                    plane_ray_pkg::coord_t y,
                                                    plane_ray_pkg::coord_t z);
        return '{plane_ray_pkg::data_t'(x), plane_ray_pkg::data_t'(y),
                 plane_ray_pkg::data_t'(z)};
    endfunction

    function automatic plane_ray_pkg::data_t comp(plane_ray_pkg::vec3_t v, int unsigned i);
        case (i)
            0:       return v.x;
            1:       return v.y;
            default: return v.z;
        endcase
    endfunction

    assign dot_idx = (state == plane_ray_pkg::DOT_X) ? 0 :
                     (state == plane_ray_pkg::DOT_Y) ? 1 : 2;

    // ----------------------------------------------------------
    // Operand routing
    // ----------------------------------------------------------
    always_comb begin
        lane_en = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            lane_op[i] = plane_ray_pkg::OP_MUL;
            lane_a[i]  = '0;
            lane_b[i]  = '0;
            lane_c[i]  = '0;
        end
        case (state)
            plane_ray_pkg::VDIFF: begin
                lane_en = '1;
                for (int i = 0; i < 3; i++) begin
                    lane_op[i]   = plane_ray_pkg::OP_SUB;
                    lane_a[i]    = comp(p1, i);        // AB
                    lane_c[i]    = comp(p0, i);
                    lane_op[i+3] = plane_ray_pkg::OP_SUB;
                    lane_a[i+3]  = comp(p2, i);        // AC
                    lane_c[i+3]  = comp(p0, i);
                end
            end
            plane_ray_pkg::VDIFF_PR: begin
                lane_en = 6'b000111;
                for (int i = 0; i < 3; i++) begin
                    lane_op[i] = plane_ray_pkg::OP_SUB;
                    lane_a[i]  = comp(p0, i);
                    lane_c[i]  = comp(r0, i);
                end
            end
            plane_ray_pkg::NORM_MUL: begin
                lane_en   = 6'b010101;
                lane_a[0] = ab.y;
                lane_b[0] = ac.z;
                lane_a[2] = ab.z;
                lane_b[2] = ac.x;
                lane_a[4] = ab.x;
                lane_b[4] = ac.y;
            end
            plane_ray_pkg::NORM_SUB: begin
                lane_en = 6'b101010;
                for (int i = 1; i < `NUM_LANES; i += 2) begin
                    lane_op[i] = plane_ray_pkg::OP_NMAC;
                end
                lane_a[1] = ab.z;
                lane_b[1] = ac.y;
                lane_c[1] = cross_pos.x;
                lane_a[3] = ab.x;
                lane_b[3] = ac.z;
                lane_c[3] = cross_pos.y;
                lane_a[5] = ab.y;
                lane_b[5] = ac.x;
                lane_c[5] = cross_pos.z;
            end
            plane_ray_pkg::DOT_X, plane_ray_pkg::DOT_Y, plane_ray_pkg::DOT_Z: begin
                lane_en[dot_idx]     = 1'b1;     // PR . n on lanes 0-2
                lane_op[dot_idx]     = plane_ray_pkg::OP_MAC;
                lane_a[dot_idx]      = comp(pr, dot_idx);
                lane_b[dot_idx]      = comp(nrm, dot_idx);
                lane_c[dot_idx]      = num_acc;
                lane_en[dot_idx + 3] = 1'b1;     // rd . n on lanes 3-5
                lane_op[dot_idx + 3] = plane_ray_pkg::OP_MAC;
                lane_a[dot_idx + 3]  = comp(rd, dot_idx);
                lane_b[dot_idx + 3]  = comp(nrm, dot_idx);
                lane_c[dot_idx + 3]  = den_acc;
            end
            default: ;
        endcase
    end

    assign lane_vi = issued ? '0 : lane_en;   // Issue only in a stage's first cycle

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        mac_lane u_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .valid_i  (lane_vi[g]),
            .op_i     (lane_op[g]),
            .a_i      (lane_a[g]),
            .b_i      (lane_b[g]),
            .c_i      (lane_c[g]),
            .valid_o  (lane_vo[g]),
            .result_o (lane_res[g])
        );
    end

    // ----------------------------------------------------------
    // Stage sequencing
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= plane_ray_pkg::IDLE;
            issued   <= 1'b0;
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
            bus.num  <= '0;
            bus.den  <= '0;
        end else begin
            bus.done <= 1'b0;
            issued   <= issued || (|lane_vi);
            case (state)
                plane_ray_pkg::IDLE: begin
                    if (bus.start) begin
                        state    <= plane_ray_pkg::VDIFF;
                        bus.busy <= 1'b1;
                    end
                end
                plane_ray_pkg::VDIFF: begin
                    state  <= plane_ray_pkg::VDIFF_PR;   // No wait, lanes stay in flight
                    issued <= 1'b0;
                end
                plane_ray_pkg::VDIFF_PR: begin
                    if (lane_vo[0] && !lane_vo[3]) begin   // PR is the last return
                        state  <= plane_ray_pkg::NORM_MUL;
                        issued <= 1'b0;
                    end
                end
                plane_ray_pkg::NORM_MUL: begin
                    if (lane_vo[0]) begin
                        state  <= plane_ray_pkg::NORM_SUB;
                        issued <= 1'b0;
                    end
                end
                plane_ray_pkg::NORM_SUB: begin
                    if (lane_vo[1]) begin
                        state  <= plane_ray_pkg::DOT_X;
                        issued <= 1'b0;
                    end
                end
                plane_ray_pkg::DOT_X, plane_ray_pkg::DOT_Y, plane_ray_pkg::DOT_Z: begin
                    if (lane_vo[dot_idx]) begin
                        state  <= (state == plane_ray_pkg::DOT_X) ? plane_ray_pkg::DOT_Y :
                                  (state == plane_ray_pkg::DOT_Y) ? plane_ray_pkg::DOT_Z :
                                                                    plane_ray_pkg::FINISH;
                        issued <= 1'b0;
                    end
                end
                plane_ray_pkg::FINISH: begin
                    state    <= plane_ray_pkg::IDLE;
                    bus.busy <= 1'b0;
                    bus.done <= 1'b1;
                    bus.num  <= num_acc;
                    bus.den  <= den_acc;
                end
                default: state <= plane_ray_pkg::IDLE;
            endcase
        end
    end

    // Coordinate latch and lane result capture
    always_ff @(posedge clk) begin
        if (state == plane_ray_pkg::IDLE && bus.start) begin
            p0      <= to_vec(bus.coords[0], bus.coords[1], bus.coords[2]);
            p1      <= to_vec(bus.coords[3], bus.coords[4], bus.coords[5]);
            p2      <= to_vec(bus.coords[6], bus.coords[7], bus.coords[8]);
            r0      <= to_vec(bus.coords[9], bus.coords[10], bus.coords[11]);
            rd      <= to_vec(bus.coords[12], bus.coords[13], bus.coords[14]);
            num_acc <= '0;
            den_acc <= '0;
        end
        case (state)
            plane_ray_pkg::VDIFF_PR: begin
                if (lane_vo[3]) begin                    // AB and AC return together
                    ab <= '{lane_res[0], lane_res[1], lane_res[2]};
                    ac <= '{lane_res[3], lane_res[4], lane_res[5]};
                end else if (lane_vo[0]) begin
                    pr <= '{lane_res[0], lane_res[1], lane_res[2]};
                end
            end
            plane_ray_pkg::NORM_MUL: begin
                if (lane_vo[0]) cross_pos <= '{lane_res[0], lane_res[2], lane_res[4]};
            end
            plane_ray_pkg::NORM_SUB: begin
                if (lane_vo[1]) nrm <= '{lane_res[1], lane_res[3], lane_res[5]};
            end
            plane_ray_pkg::DOT_X, plane_ray_pkg::DOT_Y, plane_ray_pkg::DOT_Z: begin
                if (lane_vo[dot_idx]) begin
                    num_acc <= lane_res[dot_idx];
                    den_acc <= lane_res[dot_idx + 3];
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/plane_ray_top.sv
`default_nettype none
`include "plane_ray_cfg.svh"

module plane_ray_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [`AXI_ADDR_W-1:0]    s_axi_awaddr_i,
    input  wire                      s_axi_awvalid_i,
    output logic                     s_axi_awready_o,
    input  wire [`AXI_DATA_W-1:0]    s_axi_wdata_i,
    input  wire [`AXI_DATA_W/8-1:0]  s_axi_wstrb_i,
    input  wire                      s_axi_wvalid_i,
    output logic                     s_axi_wready_o,
    output logic [1:0]               s_axi_bresp_o,
    output logic                     s_axi_bvalid_o,
    input  wire                      s_axi_bready_i,
    input  wire [`AXI_ADDR_W-1:0]    s_axi_araddr_i,
    input  wire                      s_axi_arvalid_i,
    output logic                     s_axi_arready_o,
    output logic [`AXI_DATA_W-1:0]   s_axi_rdata_o,
    output logic [1:0]               s_axi_rresp_o,
    output logic                     s_axi_rvalid_o,
    input  wire                      s_axi_rready_i
);

    plane_ray_if bus ();   // Register block to controller

    plane_ray_regs u_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .bus             (bus)
    );

    plane_ray_ctrl u_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset released on a falling edge, away from the DUT's sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_plane_ray.sv
`default_nettype none
`include "plane_ray_cfg.svh"

module tb_plane_ray;

    localparam int NUM_TRIALS  = 40;
    localparam int BP_TRIALS   = 8;                       // Last trials use back-pressure
    localparam int CYCLE_LIMIT = NUM_TRIALS * 200 + 2000;

    logic        clk;
    logic        rst_n;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [31:0]       lfsr;
    logic              stall_en;     // Random bready/rready delays
    int                cycle_cnt = 0;
    logic [14:0][15:0] cur;          // p0 p1 p2 r0 rd with xyz each
    logic [14:0][15:0] first;
    logic [31:0]       st;
    longint            got_num;
    longint            got_den;
    longint            exp_num;
    longint            exp_den;

    tb_clock_gen #(.PERIOD(100), .RST_CYCLES(3)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

    plane_ray_top uut (
        .clk(clk), .rst_n(rst_n),
        .s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
        .s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid),
        .s_axi_wready_o(wready), .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid),
        .s_axi_bready_i(bready), .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid),
        .s_axi_arready_o(arready), .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp),
        .s_axi_rvalid_o(rvalid), .s_axi_rready_i(rready)
    );

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int stall_cycles();
        return stall_en ? int'(rand_bits(3)) : 0;
    endfunction

    function automatic logic [7:0] coord_addr(input int i);
        return 8'(`REG_COORD_BASE + 4 * i);
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // Reference model of AB, AC, PR, n = AB x AC, then PR.n and rd.n
    function automatic void plane_model(input logic [14:0][15:0] c,
                                        output longint num, output longint den);
        longint v [15];
        longint ab [3];
        longint ac [3];
        longint pr [3];
        longint n [3];
        for (int i = 0; i < 15; i++) begin
            v[i] = longint'($signed(c[i]));
        end
        for (int i = 0; i < 3; i++) begin
            ab[i] = v[3 + i] - v[i];
            ac[i] = v[6 + i] - v[i];
            pr[i] = v[i] - v[9 + i];
        end
        n[0] = ab[1] * ac[2] - ab[2] * ac[1];
        n[1] = ab[2] * ac[0] - ab[0] * ac[2];
        n[2] = ab[0] * ac[1] - ab[1] * ac[0];
        num  = pr[0] * n[0] + pr[1] * n[1] + pr[2] * n[2];
        den  = v[12] * n[0] + v[13] * n[1] + v[14] * n[2];
    endfunction

    // ----------------------------------------------------------
    // AXI4-Lite master tasks
    // ----------------------------------------------------------
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int wait_n;
        wait_n = stall_cycles();
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(posedge clk);                   // bvalid is low, so this edge takes the write
        check_value({awready, wready}, 2'b11, "awready and wready at write handshake");
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_value(bvalid, 1, "bvalid after write handshake");
        check_value(bresp, 0, "bresp OKAY");
        repeat (wait_n) begin
            @(negedge clk);
            check_value(bvalid, 1, "bvalid held under back-pressure");
        end
        bready = 1'b1;
        @(negedge clk);
        check_value(bvalid, 0, "bvalid cleared after bready");
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int          wait_n;
        logic [31:0] held;
        wait_n = stall_cycles();
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        @(posedge clk);                   // rvalid is low, so this edge takes the read
        check_value(arready, 1, "arready at read handshake");
        @(negedge clk);
        arvalid = 1'b0;
        check_value(rvalid, 1, "rvalid after read handshake");
        held    = rdata;
        check_value(rresp, 0, "rresp OKAY");
        repeat (wait_n) begin
            @(negedge clk);
            check_value(rvalid, 1, "rvalid held under back-pressure");
            check_value(rdata, held, "rdata stable under back-pressure");
        end
        rready = 1'b1;
        @(negedge clk);
        check_value(rvalid, 0, "rvalid cleared after rready");
        rready = 1'b0;
        data   = held;
    endtask

    // ----------------------------------------------------------
    // Engine helpers
    // ----------------------------------------------------------
    task automatic write_coords(input logic [14:0][15:0] c);
        for (int i = 0; i < 15; i++) begin
            axi_write(coord_addr(i), {{16{c[i][15]}}, c[i]});
        end
    endtask

    task automatic readback_coords(input logic [14:0][15:0] c);
        logic [31:0] d;
        for (int i = 0; i < 15; i++) begin
            axi_read(coord_addr(i), d);
            check_value(d, {{16{c[i][15]}}, c[i]}, $sformatf("coord %0d readback", i));
        end
    endtask

    task automatic wait_done();
        logic [31:0] s;
        s = '0;
        while (!s[1]) axi_read(`REG_STATUS, s);
        check_value(s, 32'h2, "STATUS after done");
    endtask

    task automatic read_results(output longint num, output longint den);
        logic [31:0] lo;
        logic [31:0] hi;
        axi_read(`REG_NUM_LO, lo);
        axi_read(`REG_NUM_HI, hi);
        num = longint'({hi, lo});
        axi_read(`REG_DEN_LO, lo);
        axi_read(`REG_DEN_HI, hi);
        den = longint'({hi, lo});
    endtask

    task automatic run_and_compare(input logic [14:0][15:0] c, input int tag);
        longint n_exp;
        longint d_exp;
        longint n_got;
        longint d_got;
        write_coords(c);
        readback_coords(c);
        axi_write(`REG_CTRL, 32'h1);
        wait_done();
        read_results(n_got, d_got);
        plane_model(c, n_exp, d_exp);
        check_value(n_got, n_exp, $sformatf("trial %0d numerator", tag));
        check_value(d_got, d_exp, $sformatf("trial %0d denominator", tag));
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $fatal(1, "Run stopped by timeout");
        end
    end

    initial begin
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        lfsr     = 32'h60eec976;
        stall_en = 1'b0;
        wait (rst_n === 1'b1);

        // Reset state
        check_value({awready, wready, bvalid, arready, rvalid}, 0,
                    "handshake outputs after reset");
        axi_read(`REG_STATUS, st);
        check_value(st, 0, "STATUS after reset");
        for (int a = `REG_NUM_LO; a <= `REG_DEN_HI; a += 4) begin
            axi_read(8'(a), st);
            check_value(st, 0, $sformatf("result word %h after reset", a));
        end
        readback_coords('0);

        // Holes, CTRL and a read-only STATUS
        axi_read(8'h00, st);
        check_value(st, 0, "CTRL reads zero");
        axi_read(8'h18, st);
        check_value(st, 0, "unmapped 0x18");
        axi_read(8'h42, st);
        check_value(st, 0, "misaligned 0x42");
        axi_read(8'h7C, st);
        check_value(st, 0, "unmapped 0x7C");
        axi_write(`REG_STATUS, 32'hFFFF_FFFF);
        axi_read(`REG_STATUS, st);
        check_value(st, 0, "STATUS unchanged by write");

        for (int t = 0; t < NUM_TRIALS; t++) begin
            stall_en = (t >= NUM_TRIALS - BP_TRIALS);
            for (int i = 0; i < 15; i++) begin
                cur[i] = 16'(rand_bits(16));
            end
            if (t == 0) begin                // Extreme coordinates
                cur = {16'h7FFF, 16'h8000, 16'h8000, 16'h8000, 16'h7FFF, 16'h7FFF,
                       16'h7FFF, 16'h7FFF, 16'h8000, 16'h8000, 16'h8000, 16'h7FFF,
                       16'h8000, 16'h8000, 16'h8000};
            end else if (t == 1) begin       // Triangle in a z plane with a parallel ray
                cur[5]  = cur[2];
                cur[8]  = cur[2];
                cur[14] = '0;
            end else if (t == 2) begin
                cur = {15{16'h8000}};
            end
            run_and_compare(cur, t);
        end

        // Second start while the first run is still busy
        stall_en = 1'b0;
        for (int i = 0; i < 15; i++) begin
            cur[i] = 16'(rand_bits(16));
        end
        write_coords(cur);
        axi_write(`REG_CTRL, 32'h1);
        first = cur;
        for (int i = 0; i < 3; i++) begin
            cur[i] = 16'(rand_bits(16));
            axi_write(coord_addr(i), {{16{cur[i][15]}}, cur[i]});
        end
        axi_write(`REG_CTRL, 32'h1);
        axi_read(`REG_STATUS, st);
        check_value(st, 32'h1, "busy and no done while the first run is underway");
        wait_done();
        read_results(got_num, got_den);
        plane_model(first, exp_num, exp_den);
        check_value(got_num, exp_num, "overlapped start numerator");
        check_value(got_den, exp_den, "overlapped start denominator");
        for (int i = 0; i < 14; i++) begin   // Longer than one whole run
            axi_read(`REG_STATUS, st);
            check_value(st, 32'h2, "no second run after ignored start");
        end
        readback_coords(cur);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/plane_ray_pkg.sv
verilog/plane_ray_if.sv
verilog/mac_lane.sv
verilog/plane_ray_regs.sv
verilog/plane_ray_ctrl.sv
verilog/plane_ray_top.sv
tests/tb_clock_gen.sv
tests/tb_plane_ray.sv

//--- Makefile
TB_TOP  = tb_plane_ray
RTL_TOP = plane_ray_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(RTL_TOP) -f verilog.f

sim:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TB_TOP) -f verilog.f
	out=$$(./obj_dir/V$(TB_TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
